/* flist.f */
hw/tdd_pkg.sv
hw/tdd_regmap.sv
hw/tdd_sync_gen.sv
hw/tdd_frame_counter.sv
hw/tdd_channel_gen.sv
hw/tdd_top.sv
test/tb_clock_gen.sv
test/tdd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the run from its log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tdd_tb \
  -f flist.f --Mdir obj_dir -o tdd_sim > build.log 2>&1 \
  && ./obj_dir/tdd_sim > sim.log 2>&1
grep -qsF "** PASS **" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* test/tdd_tb.sv */
/*
  testbench of the TDD timing controller
  register bus tasks and random programming from a fixed seed
  cycle-level reference model of sync generator, frame counter and channels
  per-cycle output checks, directed checks, timeout and summary
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_tb;

  localparam int NUM_CHANNELS = 4;
  localparam int SYNC_STAGES = 2;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int NUM_MAPPED = 5 + 2 * NUM_CHANNELS;

  logic                    clk;
  logic                    resetn;
  logic                    wr_en;
  logic                    rd_en;
  tdd_pkg::tdd_addr_t      wr_addr;
  tdd_pkg::tdd_data_t      wr_data;
  tdd_pkg::tdd_addr_t      rd_addr;
  tdd_pkg::tdd_data_t      rd_data;
  logic                    sync_in;
  logic                    sync_out;
  logic                    tdd_running;
  logic [NUM_CHANNELS-1:0] tdd_channel;

  integer seed = 6473;
  int     error_count = 0;
  int     cycle_count = 0;
  string  test_name = "reset";

  tb_clock_gen i_clock_gen (
    .clk(clk),
    .resetn(resetn)
  );

  tdd_top #(
    .NUM_CHANNELS(NUM_CHANNELS),
    .SYNC_STAGES(SYNC_STAGES)
  ) UUT (
    .clk(clk),
    .resetn(resetn),
    .wr_en(wr_en),
    .rd_en(rd_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .sync_in(sync_in),
    .sync_out(sync_out),
    .tdd_running(tdd_running),
    .tdd_channel(tdd_channel)
  );

  // ****************************************
  // helpers
  // ****************************************

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    error_count++;
    $display("FAILED %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    error_count++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  // word address of the n-th mapped register, global words first, then channels
  function automatic tdd_pkg::tdd_addr_t mapped_addr(input int n);
    return (n < 5) ? 8'(n) : 8'(16 + n - 5);
  endfunction

  function automatic tdd_pkg::tdd_addr_t unmapped_addr();
    tdd_pkg::tdd_addr_t a;
    a = 8'(rand_range(0, 255));
    while (a <= 8'h04 || (a >= 8'h10 && a < 8'(16 + 2 * NUM_CHANNELS))) begin
      a = 8'(rand_range(0, 255));
    end
    return a;
  endfunction

  // CTRL keeps three flag bits, BURST_COUNT sixteen, SOFT_SYNC has no storage
  function automatic logic [31:0] expected_readback(input tdd_pkg::tdd_addr_t a,
                                                    input logic [31:0] d);
    case (a)
      8'h00: return d & 32'h7;
      8'h01: return 32'h0;
      8'h03: return d & 32'hffff;
      default: return d;
    endcase
  endfunction

  task automatic write_reg(input tdd_pkg::tdd_addr_t addr, input logic [31:0] data);
    @(posedge clk);
    wr_en <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // rd_data is valid from the cycle after the strobe
  task automatic read_reg(input tdd_pkg::tdd_addr_t addr, output logic [31:0] data);
    @(posedge clk);
    rd_en <= 1'b1;
    rd_addr <= addr;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    data = rd_data;
  endtask

  task automatic wait_running(input logic level, input int limit);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(negedge clk);
      seen = (tdd_running === level);
    end
    assert (seen)
      else report_problem($sformatf("tdd_running never went to %0b in %0d cycles",
                                    level, limit));
  endtask

  // each pulse must show up on sync_out exactly SYNC_STAGES+1 cycles after it rises
  task automatic send_ext_pulses(input logic pulse_expected, input int count);
    int hold;
    int gap;
    for (int p = 0; p < count; p++) begin
      hold = rand_range(2, 6);
      gap = rand_range(SYNC_STAGES + 3, 10);
      @(posedge clk);
      sync_in <= 1'b1;
      for (int j = 1; j <= hold + gap; j++) begin
        @(posedge clk);
        if (j == hold) begin
          sync_in <= 1'b0;
        end
        @(negedge clk);
        assert (sync_out === (pulse_expected && j == SYNC_STAGES + 1))
          else report_mismatch($sformatf("sync_out %0d cycles after edge", j),
                               32'(pulse_expected && j == SYNC_STAGES + 1), 32'(sync_out));
      end
    end
  endtask

  // one soft-synced burst, tdd_running must stay high for burst frames exactly
  task automatic run_frames(input int frame_len, input int burst);
    int  high;
    logic done;
    write_reg(tdd_pkg::FRAME_LEN, 32'(frame_len));
    write_reg(tdd_pkg::BURST_COUNT, 32'(burst));
    write_reg(tdd_pkg::CTRL, 32'h1);
    write_reg(tdd_pkg::SOFT_SYNC, $random(seed));
    wait_running(1'b1, 10);
    high = 1;
    done = 1'b0;
    while (!done && high < burst * frame_len + 10) begin
      @(negedge clk);
      if (tdd_running) begin
        high++;
      end else begin
        done = 1'b1;
      end
    end
    assert (high == burst * frame_len)
      else report_mismatch("tdd_running length", 32'(burst * frame_len), 32'(high));
    write_reg(tdd_pkg::CTRL, 32'h0);
  endtask

  // window kinds: normal, empty, past the frame end, fully random
  task automatic program_channel(input int k, input int frame_len);
    int   on_t;
    int   off_t;
    logic pol;
    case (rand_range(0, 3))
      0: begin
        on_t = rand_range(0, frame_len - 2);
        off_t = rand_range(on_t + 1, frame_len);
      end
      1: begin
        on_t = rand_range(0, frame_len - 1);
        off_t = rand_range(0, on_t);
      end
      2: begin
        on_t = rand_range(0, frame_len - 1);
        off_t = rand_range(frame_len + 1, frame_len + 20);
      end
      default: begin
        on_t = rand_range(0, frame_len + 4);
        off_t = rand_range(0, frame_len + 4);
      end
    endcase
    pol = (rand_range(0, 1) == 1);
    write_reg(8'(16 + 2 * k), 32'(on_t));
    write_reg(8'(17 + 2 * k), {pol, 31'(off_t)});
  endtask

  // ****************************************
  // reference model
  // ****************************************

  tdd_pkg::tdd_cfg_t       m_cfg;
  tdd_pkg::tdd_ch_cfg_t    m_ch_cfg [NUM_CHANNELS];
  logic                    m_soft;
  tdd_pkg::tdd_time_t      m_elapsed;
  logic [7:0]              m_hist;
  logic                    m_sync;
  tdd_pkg::tdd_state_e     m_state;
  tdd_pkg::tdd_time_t      m_ftime;
  logic [15:0]             m_frames;
  logic [NUM_CHANNELS-1:0] m_ch;

  // sees the inputs as they were before this edge, like the DUT does
  always @(posedge clk) begin : reference_model
    logic int_run;
    logic int_fire;
    logic ext_edge;
    logic wrap;
    logic in_win;
    if (!resetn) begin
      m_cfg <= '0;
      for (int k = 0; k < NUM_CHANNELS; k++) begin
        m_ch_cfg[k] <= '0;
      end
      m_soft <= 1'b0;
      m_elapsed <= '0;
      m_hist <= '0;
      m_sync <= 1'b0;
      m_state <= tdd_pkg::idle;
      m_ftime <= '0;
      m_frames <= '0;
      m_ch <= '0;
    end else begin
      // internal source fires once per sync_period cycles of running
      int_run = m_cfg.enable & m_cfg.sync_int_en & (m_cfg.sync_period != '0);
      int_fire = int_run & (({1'b0, m_elapsed} + 33'd1) >= {1'b0, m_cfg.sync_period});
      m_elapsed <= (!int_run || int_fire) ? '0 : m_elapsed + 32'd1;
      // m_hist[k] is sync_in as sampled k edges back
      m_hist <= {m_hist[6:0], sync_in};
      ext_edge = m_hist[SYNC_STAGES-1] & ~m_hist[SYNC_STAGES];
      m_sync <= int_fire | (m_cfg.enable & m_cfg.sync_ext_en & ext_edge) | m_soft;
      m_soft <= wr_en & (wr_addr == tdd_pkg::SOFT_SYNC) & m_cfg.enable;
      // frame counter
      case (m_state)
        tdd_pkg::idle: begin
          m_ftime <= '0;
          m_frames <= '0;
          if (m_cfg.enable) begin
            m_state <= tdd_pkg::armed;
          end
        end
        tdd_pkg::armed: begin
          m_ftime <= '0;
          m_frames <= '0;
          if (!m_cfg.enable) begin
            m_state <= tdd_pkg::idle;
          end else if (m_sync) begin
            m_state <= tdd_pkg::running;
          end
        end
        default: begin
          wrap = ({1'b0, m_ftime} + 33'd1) >= {1'b0, m_cfg.frame_len};
          if (!m_cfg.enable) begin
            m_state <= tdd_pkg::idle;
            m_ftime <= '0;
          end else if (wrap) begin
            m_ftime <= '0;
            m_frames <= m_frames + 16'd1;
            if (m_cfg.burst_count != 16'd0 && m_frames + 16'd1 == m_cfg.burst_count) begin
              m_state <= tdd_pkg::idle;
            end
          end else begin
            m_ftime <= m_ftime + 32'd1;
          end
        end
      endcase
      // channels, one cycle behind the frame time
      for (int k = 0; k < NUM_CHANNELS; k++) begin
        in_win = (m_state == tdd_pkg::running) && (m_ftime >= m_ch_cfg[k].on_time) &&
                 (m_ftime < m_ch_cfg[k].off_time);
        m_ch[k] <= in_win ^ m_ch_cfg[k].polarity;
      end
      // register writes
      if (wr_en) begin
        case (wr_addr)
          tdd_pkg::CTRL: begin
            m_cfg.enable <= wr_data[0];
            m_cfg.sync_int_en <= wr_data[1];
            m_cfg.sync_ext_en <= wr_data[2];
          end
          tdd_pkg::FRAME_LEN: m_cfg.frame_len <= wr_data;
          tdd_pkg::BURST_COUNT: m_cfg.burst_count <= wr_data[15:0];
          tdd_pkg::SYNC_PERIOD: m_cfg.sync_period <= wr_data;
          default: ;
        endcase
        for (int k = 0; k < NUM_CHANNELS; k++) begin
          if (wr_addr == 8'(16 + 2 * k)) begin
            m_ch_cfg[k].on_time <= wr_data;
          end
          if (wr_addr == 8'(17 + 2 * k)) begin
            m_ch_cfg[k].off_time <= {1'b0, wr_data[30:0]};
            m_ch_cfg[k].polarity <= wr_data[31];
          end
        end
      end
    end
  end

  // ****************************************
  // checks and timeout
  // ****************************************

  // outputs are compared on the falling edge, away from any update
  always @(negedge clk) begin
    if (resetn) begin
      assert (sync_out === m_sync)
        else report_mismatch("sync_out", 32'(m_sync), 32'(sync_out));
      assert (tdd_running === (m_state == tdd_pkg::running))
        else report_mismatch("tdd_running", 32'(m_state == tdd_pkg::running),
                             32'(tdd_running));
      assert (tdd_channel === m_ch)
        else report_mismatch("tdd_channel", 32'(m_ch), 32'(tdd_channel));
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout in %s, the run did not finish in %0d cycles", test_name,
               TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // ****************************************
  // stimulus
  // ****************************************

  initial begin : stimulus
    logic [31:0]        map_data [NUM_MAPPED];
    logic [31:0]        got;
    tdd_pkg::tdd_addr_t addr;
    int                 period;
    int                 last;
    int                 pulses;
    int                 frame_len;
    wr_en = 1'b0;
    rd_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_addr = '0;
    sync_in = 1'b0;
    wait (resetn === 1'b1);
    repeat (2) @(posedge clk);

    test_name = "register_readback";
    for (int n = 0; n < NUM_MAPPED; n++) begin
      map_data[n] = $random(seed);
      write_reg(mapped_addr(n), map_data[n]);
    end
    // writes outside the map are dropped and read back as zero
    for (int n = 0; n < 8; n++) begin
      addr = unmapped_addr();
      write_reg(addr, $random(seed));
      read_reg(addr, got);
      assert (got === 32'h0)
        else report_mismatch($sformatf("unmapped 0x%0h", addr), 32'h0, got);
    end
    for (int n = 0; n < NUM_MAPPED; n++) begin
      read_reg(mapped_addr(n), got);
      assert (got === expected_readback(mapped_addr(n), map_data[n]))
        else report_mismatch($sformatf("register 0x%0h", mapped_addr(n)),
                             expected_readback(mapped_addr(n), map_data[n]), got);
    end
    write_reg(tdd_pkg::CTRL, 32'h0);

    test_name = "internal_sync";
    period = rand_range(5, 40);
    write_reg(tdd_pkg::SYNC_PERIOD, 32'(period));
    write_reg(tdd_pkg::FRAME_LEN, 32'(rand_range(8, 30)));
    write_reg(tdd_pkg::BURST_COUNT, 32'h0);
    write_reg(tdd_pkg::CTRL, 32'h3);
    last = -1;
    pulses = 0;
    for (int i = 0; i < 8 * period; i++) begin
      @(negedge clk);
      if (sync_out) begin
        if (last >= 0) begin
          assert (i - last == period)
            else report_mismatch("sync interval", 32'(period), 32'(i - last));
        end
        last = i;
        pulses++;
      end
    end
    assert (pulses == 7)
      else report_mismatch("internal sync count", 32'd7, 32'(pulses));
    write_reg(tdd_pkg::CTRL, 32'h0);
    @(posedge clk);
    for (int i = 0; i < 3 * period; i++) begin
      @(negedge clk);
      assert (sync_out === 1'b0)
        else report_problem("sync_out pulsed while the controller was disabled");
    end

    test_name = "external_sync";
    write_reg(tdd_pkg::CTRL, 32'h5);
    send_ext_pulses(1'b1, 8);
    write_reg(tdd_pkg::CTRL, 32'h1);
    send_ext_pulses(1'b0, 6);
    write_reg(tdd_pkg::CTRL, 32'h0);
    repeat (3) @(posedge clk);

    test_name = "frames_burst";
    run_frames(rand_range(4, 20), rand_range(1, 5));
    repeat (2) @(posedge clk);
    // an endless burst keeps running until software clears enable
    frame_len = rand_range(4, 20);
    write_reg(tdd_pkg::FRAME_LEN, 32'(frame_len));
    write_reg(tdd_pkg::BURST_COUNT, 32'h0);
    write_reg(tdd_pkg::CTRL, 32'h1);
    write_reg(tdd_pkg::SOFT_SYNC, $random(seed));
    wait_running(1'b1, 10);
    for (int i = 0; i < 4 * frame_len; i++) begin
      @(negedge clk);
      assert (tdd_running === 1'b1)
        else report_problem("tdd_running dropped during an endless burst");
    end
    write_reg(tdd_pkg::CTRL, 32'h0);
    @(posedge clk);
    @(negedge clk);
    assert (tdd_running === 1'b0)
      else report_problem("tdd_running stayed high after enable was cleared");

    test_name = "channel_windows";
    for (int round = 0; round < 4; round++) begin
      frame_len = rand_range(8, 32);
      for (int k = 0; k < NUM_CHANNELS; k++) begin
        program_channel(k, frame_len);
      end
      run_frames(frame_len, rand_range(2, 3));
      repeat (3) @(posedge clk);
    end

    repeat (4) @(posedge clk);
    $display("summary: %0d errors after %0d cycles", error_count, cycle_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
/*
  testbench clock and reset source
  free-running clock and a synchronous active-low reset
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset is released on a rising edge so the DUT leaves it cleanly
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

`default_nettype wire

/* hw/tdd_top.sv */
/*
  top level of the TDD timing controller
  register file, sync generator and frame counter in a chain
  generated bank of channel generators
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_top #(
  parameter int NUM_CHANNELS = 4,
  parameter int SYNC_STAGES = 2
) (
  input  logic                    clk,
  input  logic                    resetn,

  // register bus
  input  logic                    wr_en,
  input  logic                    rd_en,
  input  tdd_pkg::tdd_addr_t      wr_addr,
  input  tdd_pkg::tdd_data_t      wr_data,
  input  tdd_pkg::tdd_addr_t      rd_addr,
  output tdd_pkg::tdd_data_t      rd_data,

  // sync and TDD control lines
  input  logic                    sync_in,
  output logic                    sync_out,
  output logic                    tdd_running,
  output logic [NUM_CHANNELS-1:0] tdd_channel
);

  tdd_pkg::tdd_cfg_t                       cfg;
  tdd_pkg::tdd_ch_cfg_t [NUM_CHANNELS-1:0] ch_cfg;
  logic                                    sync_soft;
  logic                                    tdd_sync;
  tdd_pkg::tdd_time_t                      frame_time;
  logic                                    active;

  // ****************************************
  // control chain
  // ****************************************

  tdd_regmap #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) i_regmap (
    .clk(clk),
    .resetn(resetn),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_en(rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .cfg(cfg),
    .ch_cfg(ch_cfg),
    .sync_soft(sync_soft)
  );

  tdd_sync_gen #(
    .SYNC_STAGES(SYNC_STAGES)
  ) i_sync_gen (
    .clk(clk),
    .resetn(resetn),
    .cfg(cfg),
    .sync_in(sync_in),
    .sync_soft(sync_soft),
    .tdd_sync(tdd_sync)
  );

  // frame start stays inside the controller, no channel taps it yet
  tdd_frame_counter i_frame_counter (
    .clk(clk),
    .resetn(resetn),
    .cfg(cfg),
    .tdd_sync(tdd_sync),
    .frame_time(frame_time),
    .active(active),
    .frame_start()
  );

  // the sync pulse seen by the frame counter is also made visible outside
  assign sync_out = tdd_sync;
  assign tdd_running = active;

  // ****************************************
  // channel bank
  // ****************************************

  for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_channel
    tdd_channel_gen i_channel (
      .clk(clk),
      .resetn(resetn),
      .ch_cfg(ch_cfg[k]),
      .frame_time(frame_time),
      .active(active),
      .ch_out(tdd_channel[k])
    );
  end

endmodule

`default_nettype wire

/* hw/tdd_channel_gen.sv */
/*
  one TDD control channel
  on/off window compare against the frame time
  polarity and registered control output
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_channel_gen (
  input  logic                 clk,
  input  logic                 resetn,

  input  tdd_pkg::tdd_ch_cfg_t ch_cfg,
  input  tdd_pkg::tdd_time_t   frame_time,
  input  logic                 active,
  output logic                 ch_out
);

  logic past_on;
  logic before_off;
  logic in_window;

  // ****************************************
  // window compare
  // ****************************************

  // the on point is inclusive
  assign past_on = (frame_time >= ch_cfg.on_time);

  // the off point is exclusive, so off_time equal to on_time gives an empty window
  assign before_off = (frame_time < ch_cfg.off_time);

  // an off point beyond frame_len simply keeps the line on up to the wrap
  // outside running the frame time is held at zero and must not count
  assign in_window = active & past_on & before_off;

  // ****************************************
  // output stage
  // ****************************************

  // output follows the frame time one cycle later
  // with polarity set the line idles high and drops inside the window
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ch_out <= 1'b0;
    end else begin
      ch_out <= in_window ^ ch_cfg.polarity;
    end
  end

endmodule

`default_nettype wire

/* hw/tdd_frame_counter.sv */
/*
  frame counter of the TDD controller
  idle, armed and running state machine
  frame time counter and finished-frame counter
  active and frame start flags for the channels
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_frame_counter (
  input  logic               clk,
  input  logic               resetn,

  input  tdd_pkg::tdd_cfg_t  cfg,
  input  logic               tdd_sync,
  output tdd_pkg::tdd_time_t frame_time,
  output logic               active,
  output logic               frame_start
);

  tdd_pkg::tdd_state_e state;
  tdd_pkg::tdd_burst_t frames_done;
  logic                frame_last;
  logic                burst_last;

  // last cycle of the current frame
  // a frame length of zero or one makes every cycle a full frame
  assign frame_last = (cfg.frame_len <= tdd_pkg::tdd_time_t'(1)) |
                      (frame_time >= cfg.frame_len - 1'b1);

  // the frame now ending completes the burst, never true for an endless burst
  assign burst_last = (cfg.burst_count != '0) &
                      (frames_done + 1'b1 == cfg.burst_count);

  // ****************************************
  // state machine
  // ****************************************

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= tdd_pkg::idle;
      frame_time <= '0;
      frames_done <= '0;
    end else begin
      case (state)
        // wait for software to enable the controller
        tdd_pkg::idle: begin
          frame_time <= '0;
          frames_done <= '0;
          if (cfg.enable) begin
            state <= tdd_pkg::armed;
          end
        end
        // wait for the first sync pulse, frame time stays at zero
        tdd_pkg::armed: begin
          frame_time <= '0;
          frames_done <= '0;
          if (!cfg.enable) begin
            state <= tdd_pkg::idle;
          end else if (tdd_sync) begin
            state <= tdd_pkg::running;
          end
        end
        // further sync pulses have no effect here
        tdd_pkg::running: begin
          if (!cfg.enable) begin
            state <= tdd_pkg::idle;
            frame_time <= '0;
          end else if (frame_last) begin
            frame_time <= '0;
            frames_done <= frames_done + 1'b1;
            if (burst_last) begin
              state <= tdd_pkg::idle;
            end
          end else begin
            frame_time <= frame_time + 1'b1;
          end
        end
        default: begin
          state <= tdd_pkg::idle;
          frame_time <= '0;
        end
      endcase
    end
  end

  // ****************************************
  // outputs
  // ****************************************

  assign active = (state == tdd_pkg::running);

  // marks the first cycle of every frame while running
  assign frame_start = active & (frame_time == '0);

endmodule

`default_nettype wire

/* hw/tdd_sync_gen.sv */
/*
  frame sync generator
  internal period counter
  synchronizer and rising-edge detector for the external sync input
  merge of internal, external and software sources into one pulse
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_sync_gen #(
  parameter int SYNC_STAGES = 2
) (
  input  logic              clk,
  input  logic              resetn,

  input  tdd_pkg::tdd_cfg_t cfg,
  input  logic              sync_in,
  input  logic              sync_soft,
  output logic              tdd_sync
);

  // ****************************************
  // internal source
  // ****************************************

  tdd_pkg::tdd_time_t period_cnt;
  logic               period_run;
  logic               period_hit;

  // the counter only runs while the internal source can actually fire
  assign period_run = cfg.enable & cfg.sync_int_en & (cfg.sync_period != '0);

  // a shrinking period must not leave the counter above its new limit
  assign period_hit = period_run & (period_cnt >= cfg.sync_period - 1'b1);

  // counts 0 to sync_period-1, so one hit every sync_period cycles
  always_ff @(posedge clk) begin
    if (!resetn) begin
      period_cnt <= '0;
    end else if (!period_run || period_hit) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // ****************************************
  // external source
  // ****************************************

  logic [SYNC_STAGES-1:0] sync_meta;
  logic                   sync_prev;
  logic                   ext_edge;

  // sync_in enters at bit 0 and leaves at the top bit
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sync_meta <= '0;
      sync_prev <= 1'b0;
    end else begin
      sync_meta <= (sync_meta << 1) | SYNC_STAGES'(sync_in);
      sync_prev <= sync_meta[SYNC_STAGES-1];
    end
  end

  // one cycle of high per rising edge of the synchronized input
  assign ext_edge = sync_meta[SYNC_STAGES-1] & ~sync_prev;

  // ****************************************
  // merge
  // ****************************************

  // the soft strobe arrives already gated by enable from the register file
  // the period hit already carries the internal enable bits
  // registering here puts the external pulse SYNC_STAGES+1 cycles behind sync_in
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tdd_sync <= 1'b0;
    end else begin
      tdd_sync <= period_hit |
                  (cfg.enable & cfg.sync_ext_en & ext_edge) |
                  sync_soft;
    end
  end

endmodule

`default_nettype wire

/* hw/tdd_regmap.sv */
/*
  register file of the TDD controller
  strobe-based write and registered read port
  global and per-channel settings
  software sync strobe
*/
`timescale 1ns/1ps
`default_nettype none

module tdd_regmap #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                                 clk,
  input  logic                                 resetn,

  input  logic                                 wr_en,
  input  tdd_pkg::tdd_addr_t                   wr_addr,
  input  tdd_pkg::tdd_data_t                   wr_data,
  input  logic                                 rd_en,
  input  tdd_pkg::tdd_addr_t                   rd_addr,
  output tdd_pkg::tdd_data_t                   rd_data,

  output tdd_pkg::tdd_cfg_t                    cfg,
  output tdd_pkg::tdd_ch_cfg_t [NUM_CHANNELS-1:0] ch_cfg,
  output logic                                 sync_soft
);

  // word seen by the read port, before it is registered
  tdd_pkg::tdd_data_t rd_word;

  // ****************************************
  // write side
  // ****************************************

  // writes to addresses outside the map fall through every decode and are lost
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cfg <= '0;
      ch_cfg <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        tdd_pkg::CTRL: begin
          cfg.enable <= wr_data[tdd_pkg::CTRL_ENABLE];
          cfg.sync_int_en <= wr_data[tdd_pkg::CTRL_SYNC_INT];
          cfg.sync_ext_en <= wr_data[tdd_pkg::CTRL_SYNC_EXT];
        end
        tdd_pkg::FRAME_LEN:   cfg.frame_len <= wr_data;
        tdd_pkg::BURST_COUNT: cfg.burst_count <= wr_data[15:0];
        tdd_pkg::SYNC_PERIOD: cfg.sync_period <= wr_data;
        default: ;
      endcase
      for (int k = 0; k < NUM_CHANNELS; k++) begin
        if (wr_addr == tdd_pkg::ch_addr(k, 1'b0)) begin
          ch_cfg[k].on_time <= wr_data;
        end
        // the off point loses its top bit to the polarity flag
        if (wr_addr == tdd_pkg::ch_addr(k, 1'b1)) begin
          ch_cfg[k].off_time <= {1'b0, wr_data[30:0]};
          ch_cfg[k].polarity <= wr_data[tdd_pkg::CH_POL_BIT];
        end
      end
    end
  end

  // a SOFT_SYNC write becomes a single pulse one cycle later
  // it is dropped while the controller is disabled
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sync_soft <= 1'b0;
    end else begin
      sync_soft <= wr_en & (wr_addr == tdd_pkg::SOFT_SYNC) & cfg.enable;
    end
  end

  // ****************************************
  // read side
  // ****************************************

  // SOFT_SYNC has no storage behind it and reads as zero like unmapped words
  always_comb begin
    rd_word = '0;
    case (rd_addr)
      tdd_pkg::CTRL: begin
        rd_word[tdd_pkg::CTRL_ENABLE] = cfg.enable;
        rd_word[tdd_pkg::CTRL_SYNC_INT] = cfg.sync_int_en;
        rd_word[tdd_pkg::CTRL_SYNC_EXT] = cfg.sync_ext_en;
      end
      tdd_pkg::FRAME_LEN:   rd_word = cfg.frame_len;
      tdd_pkg::BURST_COUNT: rd_word = tdd_pkg::tdd_data_t'(cfg.burst_count);
      tdd_pkg::SYNC_PERIOD: rd_word = cfg.sync_period;
      default: ;
    endcase
    for (int k = 0; k < NUM_CHANNELS; k++) begin
      if (rd_addr == tdd_pkg::ch_addr(k, 1'b0)) begin
        rd_word = ch_cfg[k].on_time;
      end
      if (rd_addr == tdd_pkg::ch_addr(k, 1'b1)) begin
        rd_word = {ch_cfg[k].polarity, ch_cfg[k].off_time[30:0]};
      end
    end
  end

  // read data holds until the next rd_en
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

/* hw/tdd_pkg.sv */
/*
  shared definitions of the TDD timing controller
  time, data, address and burst widths
  register address map and CTRL bit positions
  global and per-channel configuration structs
  frame counter states
*/
`default_nettype none

package tdd_pkg;

  localparam int TIME_WIDTH = 32;

  typedef logic [TIME_WIDTH-1:0] tdd_time_t;
  typedef logic [31:0]           tdd_data_t;
  typedef logic [7:0]            tdd_addr_t;
  typedef logic [15:0]           tdd_burst_t;

  // ****************************************
  // register map, word addresses
  // ****************************************
  typedef enum logic [7:0] {
    CTRL        = 8'h00,
    SOFT_SYNC   = 8'h01,
    FRAME_LEN   = 8'h02,
    BURST_COUNT = 8'h03,
    SYNC_PERIOD = 8'h04,
    CH_BASE     = 8'h10
  } tdd_reg_e;

  // bit positions inside the CTRL word
  localparam int CTRL_ENABLE = 0;
  localparam int CTRL_SYNC_INT = 1;
  localparam int CTRL_SYNC_EXT = 2;

  // polarity sits in the top bit of the CH_OFF word
  localparam int CH_POL_BIT = 31;

  typedef struct packed {
    logic       enable;
    logic       sync_int_en;
    logic       sync_ext_en;
    tdd_time_t  frame_len;
    // zero here means the frame counter never stops by itself
    tdd_burst_t burst_count;
    tdd_time_t  sync_period;
  } tdd_cfg_t;

  typedef struct packed {
    tdd_time_t on_time;
    tdd_time_t off_time;
    logic      polarity;
  } tdd_ch_cfg_t;

  typedef enum logic [1:0] {
    idle,
    armed,
    running
  } tdd_state_e;

  // channel k takes two words, CH_ON first and CH_OFF right after it
  function automatic tdd_addr_t ch_addr(int unsigned k, bit is_off);
    return tdd_addr_t'(CH_BASE + 2 * k + is_off);
  endfunction

endpackage

`default_nettype wire
